//--- riscvPkg.sv
package riscvPkg;

  localparam int xlen     = 32;
  localparam int regAddrW = 5;

  typedef enum logic [6:0] {
    opLoad   = 7'b0000011,
    opStore  = 7'b0100011,
    opRtype  = 7'b0110011,
    opBranch = 7'b1100011,
    opItype  = 7'b0010011,
    opJal    = 7'b1101111,
    opJalr   = 7'b1100111,
    opAuipc  = 7'b0010111
  } opcodeT;

  typedef enum logic [3:0] {
    aluAdd = 4'd0,
    aluSub = 4'd1,
    aluAnd = 4'd2,
    aluOr  = 4'd3,
    aluXor = 4'd4,
    aluSlt = 4'd5
  } aluOpT;

  typedef enum logic [2:0] {
    immI = 3'd0,
    immS = 3'd1,
    immB = 3'd2,
    immJ = 3'd3,
    immU = 3'd4
  } immSrcT;

  typedef enum logic [1:0] {
    resAlu      = 2'd0,
    resMem      = 2'd1,
    resPcPlus4  = 2'd2,
    resPcTarget = 2'd3
  } resultSrcT;

  typedef enum logic [1:0] {
    fwdNone = 2'd0,
    fwdWb   = 2'd1,
    fwdMem  = 2'd2
  } fwdSelT;

  // one instruction word, seen through each encoding format
  typedef union packed {
    struct packed {
      logic [6:0]          funct7;
      logic [regAddrW-1:0] rs2;
      logic [regAddrW-1:0] rs1;
      logic [2:0]          funct3;
      logic [regAddrW-1:0] rd;
      opcodeT              opcode;
    } rType;
    struct packed {
      logic [11:0]         imm;
      logic [regAddrW-1:0] rs1;
      logic [2:0]          funct3;
      logic [regAddrW-1:0] rd;
      opcodeT              opcode;
    } iType;
    struct packed {
      logic [6:0]          immHi;
      logic [regAddrW-1:0] rs2;
      logic [regAddrW-1:0] rs1;
      logic [2:0]          funct3;
      logic [4:0]          immLo;
      opcodeT              opcode;
    } sType;
    struct packed {
      logic                imm12;
      logic [5:0]          imm10to5;
      logic [regAddrW-1:0] rs2;
      logic [regAddrW-1:0] rs1;
      logic [2:0]          funct3;
      logic [3:0]          imm4to1;
      logic                imm11;
      opcodeT              opcode;
    } bType;
    struct packed {
      logic [19:0]         imm;
      logic [regAddrW-1:0] rd;
      opcodeT              opcode;
    } uType;
    struct packed {
      logic                imm20;
      logic [9:0]          imm10to1;
      logic                imm11;
      logic [7:0]          imm19to12;
      logic [regAddrW-1:0] rd;
      opcodeT              opcode;
    } jType;
  } instrT;

  // sign-extended immediate from instruction bits 31..7
  function automatic logic [xlen-1:0] extendImm(input logic [31:7] bits, input immSrcT src);
    case (src)
      immI:    return {{20{bits[31]}}, bits[31:20]};
      immS:    return {{20{bits[31]}}, bits[31:25], bits[11:7]};
      immB:    return {{20{bits[31]}}, bits[7], bits[30:25], bits[11:8], 1'b0};
      immJ:    return {{12{bits[31]}}, bits[19:12], bits[20], bits[30:21], 1'b0};
      immU:    return {bits[31:12], 12'b0};
      default: return '0;
    endcase
  endfunction

endpackage

//--- pipeIfc.sv
`timescale 1ns/10ps

interface ctrlIf;
  import riscvPkg::*;

  instrT     instrD;        // decode-stage instruction
  logic      branchCondE;   // branch condition from the ALU
  immSrcT    immSrcD;
  aluOpT     aluOpE;
  logic      aluSrcE;       // 1 selects the immediate as operand b
  logic      pcTargetSrcE;  // 1 for jalr, target from the ALU
  logic      pcSrcE;        // redirect fetch
  logic      memWriteM;
  resultSrcT resultSrcM;    // picks the value forwarded from memory
  logic      regWriteW;
  resultSrcT resultSrcW;

  modport ctrl (
    input  instrD, branchCondE,
    output immSrcD, aluOpE, aluSrcE, pcTargetSrcE, pcSrcE,
    output memWriteM, resultSrcM, regWriteW, resultSrcW
  );

  modport dp (
    output instrD, branchCondE,
    input  immSrcD, aluOpE, aluSrcE, pcTargetSrcE, pcSrcE,
    input  memWriteM, resultSrcM, regWriteW, resultSrcW
  );
endinterface

interface hazardIf;
  import riscvPkg::*;

  logic [regAddrW-1:0] rs1D, rs2D;
  logic [regAddrW-1:0] rs1E, rs2E;
  logic [regAddrW-1:0] rdE, rdM, rdW;
  logic                pcSrcE;
  logic                loadE;      // execute stage holds a load
  logic                regWriteM, regWriteW;
  fwdSelT              forwardAE, forwardBE;
  logic                stallF, stallD;
  logic                flushD, flushE;

  modport dp (
    output rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW,
    input  forwardAE, forwardBE, stallF, stallD, flushD, flushE
  );

  modport ctrl (
    output pcSrcE, loadE, regWriteM, regWriteW,
    input  flushE
  );

  modport hzd (
    input  rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW,
    input  pcSrcE, loadE, regWriteM, regWriteW,
    output forwardAE, forwardBE, stallF, stallD, flushD, flushE
  );
endinterface

//--- regFile.sv
`timescale 1ns/10ps

module regFile (
  input  logic                          clk,
  input  logic                          we,
  input  logic [riscvPkg::regAddrW-1:0] ra1,
  input  logic [riscvPkg::regAddrW-1:0] ra2,
  input  logic [riscvPkg::regAddrW-1:0] wa,
  input  logic [riscvPkg::xlen-1:0]     wd,
  output logic [riscvPkg::xlen-1:0]     rd1,
  output logic [riscvPkg::xlen-1:0]     rd2
);
  import riscvPkg::*;

  logic [xlen-1:0] rf [32];

  // written mid-cycle so decode reads the new value in the same cycle
  always_ff @(negedge clk) begin
    if (we)
      rf[wa] <= wd;
  end

  assign rd1 = (ra1 != '0) ? rf[ra1] : '0;  // x0 reads as zero
  assign rd2 = (ra2 != '0) ? rf[ra2] : '0;
endmodule

//--- alu.sv
`timescale 1ns/10ps

module alu (
  input  logic [riscvPkg::xlen-1:0] a,
  input  logic [riscvPkg::xlen-1:0] b,
  input  riscvPkg::aluOpT           op,
  input  logic [2:0]                funct3,
  output logic [riscvPkg::xlen-1:0] result,
  output logic                      branchCond
);
  import riscvPkg::*;

  logic            subtract;
  logic [xlen-1:0] bOperand, sum;
  logic            overflow, lessThan, equal;

  // one adder serves add, sub, slt and branch compares
  assign subtract = (op == aluSub) || (op == aluSlt);
  assign bOperand = subtract ? ~b : b;
  assign sum      = a + bOperand + {{(xlen-1){1'b0}}, subtract};

  assign overflow = ~(a[xlen-1] ^ bOperand[xlen-1]) & (a[xlen-1] ^ sum[xlen-1]);
  assign lessThan = sum[xlen-1] ^ overflow;  // signed a < b
  assign equal    = (sum == '0);

  always_comb begin
    case (op)
      aluAdd,
      aluSub:  result = sum;
      aluAnd:  result = a & b;
      aluOr:   result = a | b;
      aluXor:  result = a ^ b;
      aluSlt:  result = {{(xlen-1){1'b0}}, lessThan};
      default: result = sum;
    endcase
  end

  // only meaningful while a branch is in execute
  always_comb begin
    case (funct3)
      3'b000:  branchCond = equal;       // beq
      3'b001:  branchCond = ~equal;      // bne
      3'b100:  branchCond = lessThan;    // blt
      3'b101:  branchCond = ~lessThan;   // bge
      default: branchCond = 1'b0;
    endcase
  end
endmodule

//--- hazardUnit.sv
`timescale 1ns/10ps

module hazardUnit (
  hazardIf.hzd hzd
);
  import riscvPkg::*;

  logic loadUse;

  // newest producer wins, x0 is never forwarded
  function automatic fwdSelT pickFwd(input logic [regAddrW-1:0] rs,
                                     input logic [regAddrW-1:0] rdM,
                                     input logic                regWriteM,
                                     input logic [regAddrW-1:0] rdW,
                                     input logic                regWriteW);
    if (rs == '0)
      return fwdNone;
    else if (regWriteM && rs == rdM)
      return fwdMem;
    else if (regWriteW && rs == rdW)
      return fwdWb;
    else
      return fwdNone;
  endfunction

  assign hzd.forwardAE = pickFwd(hzd.rs1E, hzd.rdM, hzd.regWriteM, hzd.rdW, hzd.regWriteW);
  assign hzd.forwardBE = pickFwd(hzd.rs2E, hzd.rdM, hzd.regWriteM, hzd.rdW, hzd.regWriteW);

  // load result arrives too late for the next instruction
  assign loadUse = hzd.loadE && (hzd.rdE != '0) &&
                   ((hzd.rs1D == hzd.rdE) || (hzd.rs2D == hzd.rdE));

  assign hzd.stallF = loadUse;
  assign hzd.stallD = loadUse;
  assign hzd.flushD = hzd.pcSrcE;
  assign hzd.flushE = loadUse | hzd.pcSrcE;  // bubble or wrong-path squash
endmodule

//--- controller.sv
`timescale 1ns/10ps

module controller (
  input logic clk,
  input logic reset,
  ctrlIf.ctrl ctl,
  hazardIf.ctrl hzd
);
  import riscvPkg::*;

  logic      regWriteD, aluSrcD, memWriteD;
  logic      branchD, jumpD, pcTargetSrcD;
  logic      functOpD;      // ALU op comes from funct3
  resultSrcT resultSrcD;
  immSrcT    immSrcD;
  aluOpT     aluOpD;

  logic      regWriteE, memWriteE, jumpE, branchE, aluSrcE, pcTargetSrcE;
  resultSrcT resultSrcE;
  aluOpT     aluOpE;
  logic      regWriteM, memWriteM;
  resultSrcT resultSrcM;
  logic      regWriteW;
  resultSrcT resultSrcW;
  logic      pcSrcE;

  always_comb begin
    regWriteD    = 1'b0;
    immSrcD      = immI;
    aluSrcD      = 1'b0;
    memWriteD    = 1'b0;
    resultSrcD   = resAlu;
    branchD      = 1'b0;
    jumpD        = 1'b0;
    pcTargetSrcD = 1'b0;
    functOpD     = 1'b0;
    case (ctl.instrD.rType.opcode)
      opLoad: begin
        regWriteD  = 1'b1;
        aluSrcD    = 1'b1;
        resultSrcD = resMem;
      end
      opStore: begin
        immSrcD   = immS;
        aluSrcD   = 1'b1;
        memWriteD = 1'b1;
      end
      opRtype: begin
        regWriteD = 1'b1;
        functOpD  = 1'b1;
      end
      opItype: begin
        regWriteD = 1'b1;
        aluSrcD   = 1'b1;
        functOpD  = 1'b1;
      end
      opBranch: begin
        immSrcD = immB;
        branchD = 1'b1;
      end
      opJal: begin
        regWriteD  = 1'b1;
        immSrcD    = immJ;
        resultSrcD = resPcPlus4;
        jumpD      = 1'b1;
      end
      opJalr: begin
        regWriteD    = 1'b1;
        aluSrcD      = 1'b1;
        resultSrcD   = resPcPlus4;
        jumpD        = 1'b1;
        pcTargetSrcD = 1'b1;        // target is rs1 + imm
      end
      opAuipc: begin
        regWriteD  = 1'b1;
        immSrcD    = immU;
        resultSrcD = resPcTarget;   // pc + upper immediate
      end
      default: ;                    // bubbles and unknown words do nothing
    endcase
  end

  always_comb begin
    aluOpD = aluAdd;
    if (branchD) begin
      aluOpD = aluSub;              // compare by subtraction
    end else if (functOpD) begin
      case (ctl.instrD.rType.funct3)
        3'b000:  aluOpD = (ctl.instrD.rType.opcode == opRtype &&
                           ctl.instrD.rType.funct7[5]) ? aluSub : aluAdd;
        3'b010:  aluOpD = aluSlt;
        3'b100:  aluOpD = aluXor;
        3'b110:  aluOpD = aluOr;
        3'b111:  aluOpD = aluAnd;
        default: aluOpD = aluAdd;
      endcase
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset || hzd.flushE) begin
      regWriteE    <= 1'b0;
      resultSrcE   <= resAlu;
      memWriteE    <= 1'b0;
      jumpE        <= 1'b0;
      branchE      <= 1'b0;
      aluOpE       <= aluAdd;
      aluSrcE      <= 1'b0;
      pcTargetSrcE <= 1'b0;
    end else begin
      regWriteE    <= regWriteD;
      resultSrcE   <= resultSrcD;
      memWriteE    <= memWriteD;
      jumpE        <= jumpD;
      branchE      <= branchD;
      aluOpE       <= aluOpD;
      aluSrcE      <= aluSrcD;
      pcTargetSrcE <= pcTargetSrcD;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      regWriteM  <= 1'b0;
      resultSrcM <= resAlu;
      memWriteM  <= 1'b0;
      regWriteW  <= 1'b0;
      resultSrcW <= resAlu;
    end else begin
      regWriteM  <= regWriteE;
      resultSrcM <= resultSrcE;
      memWriteM  <= memWriteE;
      regWriteW  <= regWriteM;
      resultSrcW <= resultSrcM;
    end
  end

  assign pcSrcE = (branchE & ctl.branchCondE) | jumpE;

  assign ctl.immSrcD      = immSrcD;
  assign ctl.aluOpE       = aluOpE;
  assign ctl.aluSrcE      = aluSrcE;
  assign ctl.pcTargetSrcE = pcTargetSrcE;
  assign ctl.pcSrcE       = pcSrcE;
  assign ctl.memWriteM    = memWriteM;
  assign ctl.resultSrcM   = resultSrcM;
  assign ctl.regWriteW    = regWriteW;
  assign ctl.resultSrcW   = resultSrcW;

  assign hzd.pcSrcE    = pcSrcE;
  assign hzd.loadE     = (resultSrcE == resMem);
  assign hzd.regWriteM = regWriteM;
  assign hzd.regWriteW = regWriteW;
endmodule

//--- datapath.sv
`timescale 1ns/10ps

module datapath #(
  parameter logic [riscvPkg::xlen-1:0] resetPc = '0
) (
  input  logic                      clk,
  input  logic                      reset,
  output logic [riscvPkg::xlen-1:0] pc,
  input  logic [riscvPkg::xlen-1:0] instr,
  output logic [riscvPkg::xlen-1:0] aluResultM,
  output logic [riscvPkg::xlen-1:0] writeDataM,
  input  logic [riscvPkg::xlen-1:0] readDataM,
  ctrlIf.dp                         ctl,
  hazardIf.dp                       hzd
);
  import riscvPkg::*;

  logic [xlen-1:0]     pcNextF, pcPlus4F;
  instrT               instrD;
  logic [xlen-1:0]     pcD, pcPlus4D, rd1D, rd2D, immExtD;
  logic [xlen-1:0]     rd1E, rd2E, pcE, pcPlus4E, immExtE;
  logic [2:0]          funct3E;
  logic [xlen-1:0]     srcAE, srcBE, writeDataE, aluResultE;
  logic [xlen-1:0]     pcTargetE, pcJumpE;
  logic [xlen-1:0]     pcTargetM, pcPlus4M, resultM;
  logic [xlen-1:0]     aluResultW, readDataW, pcTargetW, pcPlus4W, resultW;
  logic [regAddrW-1:0] rdE, rdM, rdW, rs1E, rs2E;

  function automatic logic [xlen-1:0] fwdMux(input logic [xlen-1:0] regVal,
                                             input logic [xlen-1:0] memVal,
                                             input logic [xlen-1:0] wbVal,
                                             input fwdSelT          sel);
    case (sel)
      fwdMem:  return memVal;
      fwdWb:   return wbVal;
      default: return regVal;
    endcase
  endfunction

  // fetch
  assign pcPlus4F = pc + 32'd4;
  assign pcNextF  = ctl.pcSrcE ? pcJumpE : pcPlus4F;

  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      pc <= resetPc;
    else if (!hzd.stallF)
      pc <= pcNextF;
  end

  // decode
  always_ff @(posedge clk or posedge reset) begin
    if (reset || hzd.flushD) begin
      instrD   <= '0;
      pcD      <= '0;
      pcPlus4D <= '0;
    end else if (!hzd.stallD) begin
      instrD   <= instr;
      pcD      <= pc;
      pcPlus4D <= pcPlus4F;
    end
  end

  assign ctl.instrD = instrD;
  assign hzd.rs1D   = instrD.rType.rs1;
  assign hzd.rs2D   = instrD.rType.rs2;
  assign immExtD    = extendImm(instrD[31:7], ctl.immSrcD);

  regFile u_regFile (
    .clk (clk),
    .we  (ctl.regWriteW),
    .ra1 (instrD.rType.rs1),
    .ra2 (instrD.rType.rs2),
    .wa  (rdW),
    .wd  (resultW),
    .rd1 (rd1D),
    .rd2 (rd2D)
  );

  // execute
  always_ff @(posedge clk or posedge reset) begin
    if (reset || hzd.flushE) begin
      rd1E     <= '0;
      rd2E     <= '0;
      pcE      <= '0;
      pcPlus4E <= '0;
      immExtE  <= '0;
      rs1E     <= '0;
      rs2E     <= '0;
      rdE      <= '0;
      funct3E  <= '0;
    end else begin
      rd1E     <= rd1D;
      rd2E     <= rd2D;
      pcE      <= pcD;
      pcPlus4E <= pcPlus4D;
      immExtE  <= immExtD;
      rs1E     <= instrD.rType.rs1;
      rs2E     <= instrD.rType.rs2;
      rdE      <= instrD.rType.rd;
      funct3E  <= instrD.rType.funct3;
    end
  end

  assign hzd.rs1E = rs1E;
  assign hzd.rs2E = rs2E;
  assign hzd.rdE  = rdE;

  assign srcAE      = fwdMux(rd1E, resultM, resultW, hzd.forwardAE);
  assign writeDataE = fwdMux(rd2E, resultM, resultW, hzd.forwardBE);
  assign srcBE      = ctl.aluSrcE ? immExtE : writeDataE;

  alu u_alu (
    .a          (srcAE),
    .b          (srcBE),
    .op         (ctl.aluOpE),
    .funct3     (funct3E),
    .result     (aluResultE),
    .branchCond (ctl.branchCondE)
  );

  assign pcTargetE = pcE + immExtE;
  assign pcJumpE   = ctl.pcTargetSrcE ? aluResultE : pcTargetE;  // jalr takes rs1 + imm

  // memory and writeback
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      aluResultM <= '0;
      writeDataM <= '0;
      rdM        <= '0;
      pcTargetM  <= '0;
      pcPlus4M   <= '0;
      aluResultW <= '0;
      readDataW  <= '0;
      rdW        <= '0;
      pcTargetW  <= '0;
      pcPlus4W   <= '0;
    end else begin
      aluResultM <= aluResultE;
      writeDataM <= writeDataE;
      rdM        <= rdE;
      pcTargetM  <= pcTargetE;
      pcPlus4M   <= pcPlus4E;
      aluResultW <= aluResultM;
      readDataW  <= readDataM;
      rdW        <= rdM;
      pcTargetW  <= pcTargetM;
      pcPlus4W   <= pcPlus4M;
    end
  end

  assign hzd.rdM = rdM;
  assign hzd.rdW = rdW;

  // memory-stage result for forwarding, a load never sits here with a consumer in execute
  always_comb begin
    case (ctl.resultSrcM)
      resPcPlus4:  resultM = pcPlus4M;
      resPcTarget: resultM = pcTargetM;
      default:     resultM = aluResultM;
    endcase
  end

  always_comb begin
    case (ctl.resultSrcW)
      resMem:      resultW = readDataW;
      resPcPlus4:  resultW = pcPlus4W;    // link address
      resPcTarget: resultW = pcTargetW;   // auipc
      default:     resultW = aluResultW;
    endcase
  end
endmodule

//--- riscvTop.sv
`timescale 1ns/10ps

module riscvTop #(
  parameter logic [riscvPkg::xlen-1:0] resetPc = '0
) (
  input  logic                      clk,
  input  logic                      reset,
  output logic [riscvPkg::xlen-1:0] pc,
  input  logic [riscvPkg::xlen-1:0] instr,
  output logic                      memWrite,
  output logic [riscvPkg::xlen-1:0] dataAdr,
  output logic [riscvPkg::xlen-1:0] writeData,
  input  logic [riscvPkg::xlen-1:0] readData
);

  ctrlIf   ctlBus ();
  hazardIf hzdBus ();

  controller u_controller (
    .clk   (clk),
    .reset (reset),
    .ctl   (ctlBus.ctrl),
    .hzd   (hzdBus.ctrl)
  );

  datapath #(
    .resetPc (resetPc)
  ) u_datapath (
    .clk        (clk),
    .reset      (reset),
    .pc         (pc),
    .instr      (instr),
    .aluResultM (dataAdr),     // memory-stage ALU result addresses data memory
    .writeDataM (writeData),
    .readDataM  (readData),
    .ctl        (ctlBus.dp),
    .hzd        (hzdBus.dp)
  );

  hazardUnit u_hazardUnit (
    .hzd (hzdBus.hzd)
  );

  assign memWrite = ctlBus.memWriteM;
endmodule

//--- riscvTb.sv
`timescale 1ns/10ps

module riscvTb;

  localparam logic [6:0] opLoad  = 7'b0000011;
  localparam logic [6:0] opImm   = 7'b0010011;
  localparam logic [6:0] opJalr  = 7'b1100111;

  logic        clk;
  logic        reset;
  logic [31:0] pc;
  logic [31:0] instr;
  logic        memWrite;
  logic [31:0] dataAdr;
  logic [31:0] writeData;
  logic [31:0] readData;

  logic [31:0] imem [64];
  logic [31:0] dmem [256];
  logic [31:0] logAdr [$];
  logic [31:0] logData [$];
  logic [31:0] expAdr [$];
  logic [31:0] expData [$];
  logic        doneSeen;
  int          emitIdx;
  int          errors;
  int          checks;
  logic [31:0] seed;

  riscvTop #(
    .resetPc (32'h0)
  ) u_dut (
    .clk       (clk),
    .reset     (reset),
    .pc        (pc),
    .instr     (instr),
    .memWrite  (memWrite),
    .dataAdr   (dataAdr),
    .writeData (writeData),
    .readData  (readData)
  );

  assign instr    = imem[pc[7:2]];      // word-addressed instruction memory
  assign readData = dmem[dataAdr[9:2]];

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // data memory write port and store log
  always @(posedge clk) begin
    if (memWrite === 1'b1) begin
      dmem[dataAdr[9:2]] <= writeData;
      logAdr.push_back(dataAdr);
      logData.push_back(writeData);
      if (dataAdr == 32'h0000_00FC)
        doneSeen = 1'b1;
    end
  end

  function automatic logic [31:0] nextRandom(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] signExtend12(input logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  function automatic logic [31:0] rFormat(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] iFormat(input logic [6:0] op, input logic [11:0] imm,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] sFormat(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};  // sw only
  endfunction

  function automatic logic [31:0] bFormat(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] uFormat(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'b0010111};  // auipc
  endfunction

  function automatic logic [31:0] jFormat(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  // expected result of each kept ALU instruction
  function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic sub,
                                           input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  return sub ? a - b : a + b;
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b110:  return a | b;
      3'b111:  return a & b;
      default: return 32'h0;
    endcase
  endfunction

  function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] a,
                                       input logic [31:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      default: return 1'b0;
    endcase
  endfunction

  task automatic placeWord(input logic [31:0] w);
    imem[emitIdx] = w;
    emitIdx++;
  endtask

  task automatic expectStore(input logic [31:0] adr, input logic [31:0] data);
    expAdr.push_back(adr);
    expData.push_back(data);
  endtask

  // random 32-bit value built by auipc and addi
  task automatic loadOperand(input logic [4:0] rd, output logic [31:0] value);
    logic [31:0] pcHere;
    seed   = nextRandom(seed);
    pcHere = 32'(emitIdx * 4);
    placeWord(uFormat(seed[31:12], rd));
    placeWord(iFormat(opImm, seed[11:0], rd, 3'b000, rd));
    value = pcHere + {seed[31:12], 12'h000} + signExtend12(seed[11:0]);
  endtask

  task automatic startReset();
    int i;
    @(posedge clk);
    #2;
    reset = 1'b1;
    for (i = 0; i < 64; i++)
      imem[i] = iFormat(opImm, i[11:0], 5'd0, 3'b000, 5'd0);  // nop, imm tracks the address
    emitIdx  = 0;
    doneSeen = 1'b0;
    logAdr.delete();
    logData.delete();
    expAdr.delete();
    expData.delete();
  endtask

  task automatic checkStores(input string name);
    int i;
    checks++;
    if (logAdr.size() != expAdr.size()) begin
      errors++;
      $display("%s test: %0d stores were logged but %0d were expected",
               name, logAdr.size(), expAdr.size());
    end
    for (i = 0; i < logAdr.size() && i < expAdr.size(); i++) begin
      checks += 2;
      if (logAdr[i] !== expAdr[i]) begin
        errors++;
        $display("FAIL t=%0t %s store %0d dataAdr expected=%h actual=%h",
                 $time, name, i, expAdr[i], logAdr[i]);
      end
      if (logData[i] !== expData[i]) begin
        errors++;
        $display("FAIL t=%0t %s store %0d writeData expected=%h actual=%h",
                 $time, name, i, expData[i], logData[i]);
      end
    end
  endtask

  // appends the done store, finishes reset, runs until done and compares
  task automatic runProgram(input string name);
    int cyc;
    placeWord(sFormat(12'h0FC, 5'd0, 5'd0));
    expectStore(32'h0000_00FC, 32'h0);
    for (cyc = 0; cyc < 9; cyc++) begin
      if (cyc == 8)
        reset = 1'b0;
      else begin
        @(posedge clk);
        #2;
      end
      checks++;
      if (memWrite !== 1'b0) begin
        errors++;
        $display("FAIL t=%0t memWrite expected=0 actual=%b", $time, memWrite);
      end
    end
    #1;
    checks++;
    if (pc !== 32'h0) begin
      errors++;
      $display("FAIL t=%0t pc expected=%h actual=%h", $time, 32'h0, pc);
    end
    @(posedge clk);
    #2;
    checks++;
    if (memWrite !== 1'b0) begin
      errors++;
      $display("FAIL t=%0t memWrite expected=0 actual=%b", $time, memWrite);
    end
    cyc = 0;
    while (!doneSeen && cyc < 2000) begin
      @(posedge clk);
      #2;
      cyc++;
    end
    if (!doneSeen) begin
      errors++;
      $display("%s test timed out: no store to the done address in 2000 cycles", name);
    end else begin
      checkStores(name);
    end
  endtask

  task automatic resetTest();
    startReset();
    runProgram("reset");
  endtask

  task automatic aluTest();
    logic [31:0] rv [32];
    logic [2:0]  f3s [11];
    bit          isReg [11];
    bit          isSub [11];
    logic [11:0] imm;
    logic [4:0]  rd, rs1, rs2;
    int          k;
    startReset();
    f3s   = '{3'b000, 3'b000, 3'b000, 3'b111, 3'b111, 3'b110,
              3'b110, 3'b100, 3'b100, 3'b010, 3'b010};
    isReg = '{1, 0, 1, 0, 1, 0, 1, 0, 1, 0, 1};
    isSub = '{0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0};
    loadOperand(5'd1, rv[1]);
    loadOperand(5'd2, rv[2]);
    for (k = 0; k < 11; k++) begin
      rd  = 5'(k + 3);
      rs1 = 5'(k + 2);  // previous result, forwarded from memory
      rs2 = 5'(k + 1);  // one older, forwarded from writeback
      if (isReg[k]) begin
        rv[rd] = aluModel(f3s[k], isSub[k], rv[rs1], rv[rs2]);
        placeWord(rFormat(isSub[k] ? 7'h20 : 7'h00, rs2, rs1, f3s[k], rd));
      end else begin
        seed   = nextRandom(seed);
        imm    = seed[11:0];
        rv[rd] = aluModel(f3s[k], 1'b0, rv[rs1], signExtend12(imm));
        placeWord(iFormat(opImm, imm, rs1, f3s[k], rd));
      end
    end
    for (k = 0; k < 11; k++) begin
      placeWord(sFormat(12'(12'h100 + 4 * k), 5'(k + 3), 5'd0));
      expectStore(32'(32'h100 + 4 * k), rv[k + 3]);
    end
    runProgram("alu");
  endtask

  task automatic loadUseTest();
    logic [31:0] a, b, sum;
    startReset();
    loadOperand(5'd1, a);
    loadOperand(5'd2, b);
    sum = a + b;
    placeWord(sFormat(12'h200, 5'd1, 5'd0));
    expectStore(32'h200, a);
    placeWord(iFormat(opLoad, 12'h200, 5'd0, 3'b010, 5'd3));  // lw x3
    placeWord(rFormat(7'h00, 5'd2, 5'd3, 3'b000, 5'd4));      // add uses x3 at once
    placeWord(sFormat(12'h204, 5'd4, 5'd0));
    expectStore(32'h204, sum);
    placeWord(iFormat(opLoad, 12'h204, 5'd0, 3'b010, 5'd5));
    placeWord(rFormat(7'h00, 5'd5, 5'd2, 3'b100, 5'd6));      // dependence on rs2
    placeWord(sFormat(12'h208, 5'd6, 5'd0));
    expectStore(32'h208, b ^ sum);
    runProgram("load-use");
  endtask

  task automatic branchTest();
    logic [31:0] n, m, a, b;
    logic [31:0] pairA [3];
    logic [31:0] pairB [3];
    logic [2:0]  kinds [4];
    logic [11:0] base;
    int          c, p;
    startReset();
    seed  = nextRandom(seed);
    n     = {21'h1FFFFF, seed[10:0]};          // -2048 to -1
    seed  = nextRandom(seed);
    m     = {21'h0, seed[10:0] | 11'h001};     // 1 to 2047
    kinds = '{3'b000, 3'b001, 3'b100, 3'b101};
    pairA = '{n, n, m};
    pairB = '{n, m, n};
    for (c = 0; c < 4; c++) begin
      for (p = 0; p < 3; p++) begin
        a    = pairA[p];
        b    = pairB[p];
        base = 12'(12'h300 + 8 * (3 * c + p));
        placeWord(iFormat(opImm, a[11:0], 5'd0, 3'b000, 5'd1));
        placeWord(iFormat(opImm, b[11:0], 5'd0, 3'b000, 5'd2));
        placeWord(bFormat(13'd8, 5'd2, 5'd1, kinds[c]));  // taken skips the next store
        placeWord(sFormat(base, 5'd1, 5'd0));
        placeWord(sFormat(base + 12'd4, 5'd2, 5'd0));
        if (!branchTaken(kinds[c], a, b))
          expectStore({20'h0, base}, a);
        expectStore({20'h0, base + 12'd4}, b);
      end
    end
    runProgram("branch");
  endtask

  task automatic jumpTest();
    logic [19:0] upper;
    logic [31:0] linkAdr;
    startReset();
    seed    = nextRandom(seed);
    upper   = seed[19:0];
    linkAdr = 32'(emitIdx * 4 + 4);
    placeWord(jFormat(21'd12, 5'd1));             // jal x1 over two stores
    placeWord(sFormat(12'h3F0, 5'd0, 5'd0));
    placeWord(sFormat(12'h3F0, 5'd0, 5'd0));
    placeWord(sFormat(12'h180, 5'd1, 5'd0));
    expectStore(32'h180, linkAdr);
    placeWord(uFormat(20'h00000, 5'd2));          // x2 = 16
    linkAdr = 32'(emitIdx * 4 + 4);
    placeWord(iFormat(opJalr, 12'd16, 5'd2, 3'b000, 5'd3));  // to address 32
    placeWord(sFormat(12'h3F4, 5'd0, 5'd0));
    placeWord(sFormat(12'h3F4, 5'd0, 5'd0));
    placeWord(sFormat(12'h184, 5'd3, 5'd0));
    expectStore(32'h184, linkAdr);
    expectStore(32'h188, 32'(emitIdx * 4) + {upper, 12'h000});
    placeWord(uFormat(upper, 5'd4));
    placeWord(sFormat(12'h188, 5'd4, 5'd0));
    runProgram("jump");
  endtask

  initial begin
    int i;
    reset    = 1'b1;
    errors   = 0;
    checks   = 0;
    seed     = 32'd1272;
    doneSeen = 1'b0;
    emitIdx  = 0;
    for (i = 0; i < 256; i++)
      dmem[i] = 32'hDA7A_0000 | i;
    for (i = 0; i < 64; i++)
      imem[i] = iFormat(opImm, i[11:0], 5'd0, 3'b000, 5'd0);
    resetTest();
    aluTest();
    loadUseTest();
    branchTest();
    jumpTest();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- verilog.f
riscvPkg.sv
pipeIfc.sv
regFile.sv
alu.sv
hazardUnit.sv
controller.sv
datapath.sv
riscvTop.sv
riscvTb.sv
